//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module lpf_coef_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vlpf_coef_tb)"; echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir

//--- bench/lpf_cases.txt
// omega0 inv_2q a2 a1 b2 b1 b0 tol, 18-bit Q2.16 hex
// tol in LSB covers the truncated series and fixed-point rounding
04000 08000 0c7a3 1b979 0038b 00715 0038b 00014
08000 04000 0c934 1913b 00dfe 01bfc 00dfe 00015
02000 0b505 0d685 1d2d9 000eb 001d6 000eb 00011
06000 02000 0e996 1c790 00881 01103 00881 00011
0c000 02000 0d7cd 15936 01fa6 03f4b 01fa6 0002e
01000 10000 0e1e7 1e0f6 0003c 00078 0003c 00011
10000 01000 0e66b 106d0 037e7 06fcd 037e7 000ba
08000 08000 09d00 16a71 00ca4 01947 00ca4 0005c

//--- bench/lpf_coef_tb.sv
/*
 * Testbench for the biquad coefficient calculator: clock, reset,
 * case file reader, stimulus, result checks and timeouts
 */
module lpf_coef_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CASES    = 8;
    localparam int CASE_WORDS   = 8;
    localparam int COL_OMEGA0   = 0;
    localparam int COL_INV2Q    = 1;
    localparam int COL_A2       = 2;
    localparam int COL_A1       = 3;
    localparam int COL_B2       = 4;
    localparam int COL_B1       = 5;
    localparam int COL_B0       = 6;
    localparam int COL_TOL      = 7;
    localparam int DONE_TIMEOUT = 2000;

    logic                    clk;
    logic                    reset;
    logic                    do_calc;
    fixp_pkg::fixp_t         omega0;
    fixp_pkg::fixp_t         inv_2q;
    lpf_coef_pkg::coef_set_t coefs;
    logic                    calc_done;
    logic                    done_prev;
    logic [17:0]             case_mem [NUM_CASES*CASE_WORDS];

    lpf_coef_top u_lpf_coef_top (
        .clk       (clk),
        .reset     (reset),
        .do_calc   (do_calc),
        .omega0    (omega0),
        .inv_2q    (inv_2q),
        .coefs     (coefs),
        .calc_done (calc_done)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_near(input string what, input int actual, input int expected,
                              input int tol);
        int diff;
        diff = actual - expected;
        if (diff < 0) begin
            diff = -diff;
        end
        if (diff > tol) begin
            abort_run($sformatf("ERR %0t: %s is %0d, expected %0d within %0d",
                                $time, what, actual, expected, tol));
        end
    endtask

    function automatic int case_word(input int idx, input int col);
        fixp_pkg::fixp_t v;
        v = case_mem[idx*CASE_WORDS + col];
        return int'(v);
    endfunction

    // One-cycle strobe with inputs cleared afterwards
    task automatic drive_calc(input fixp_pkg::fixp_t w, input fixp_pkg::fixp_t q);
        @(posedge clk);
        #2;
        do_calc = 1'b1;
        omega0  = w;
        inv_2q  = q;
        @(posedge clk);
        #2;
        do_calc = 1'b0;
        omega0  = '0;
        inv_2q  = '0;
    endtask

    task automatic drive_case(input int idx);
        drive_calc(fixp_pkg::fixp_t'(case_word(idx, COL_OMEGA0)),
                   fixp_pkg::fixp_t'(case_word(idx, COL_INV2Q)));
    endtask

    task automatic wait_calc_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!calc_done) begin
            cycles++;
            if (cycles >= DONE_TIMEOUT) begin
                abort_run("Timeout: calc_done never arrived");
            end
            @(negedge clk);
        end
    endtask

    task automatic check_result(input int idx);
        int tol;
        tol = case_word(idx, COL_TOL);
        check_near($sformatf("case %0d a2", idx), int'(coefs.a2), case_word(idx, COL_A2), tol);
        check_near($sformatf("case %0d a1", idx), int'(coefs.a1), case_word(idx, COL_A1), tol);
        check_near($sformatf("case %0d b2", idx), int'(coefs.b2), case_word(idx, COL_B2), tol);
        check_near($sformatf("case %0d b1", idx), int'(coefs.b1), case_word(idx, COL_B1), tol);
        check_near($sformatf("case %0d b0", idx), int'(coefs.b0), case_word(idx, COL_B0), tol);
        // b2 and b0 come from the same shifted value
        check_near($sformatf("case %0d b2 against b0", idx),
                   int'(coefs.b2), int'(coefs.b0), 0);
        check_near($sformatf("case %0d b1 against 2*b0", idx),
                   int'(coefs.b1), 2 * int'(coefs.b0), 2);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_near("calc_done without accepted do_calc", int'(calc_done), 0, 0);
        end
    endtask

    // --------------------
    // Output monitor
    // --------------------
    always @(negedge clk) begin
        if (reset) begin
            done_prev <= 1'b0;
        end else begin
            if (!calc_done) begin
                check_near("coefs nonzero outside calc_done", int'(coefs != '0), 0, 0);
            end
            check_near("calc_done high two cycles", int'(calc_done && done_prev), 0, 0);
            done_prev <= calc_done;
        end
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        do_calc = 1'b0;
        omega0  = '0;
        inv_2q  = '0;
        $readmemh("bench/lpf_cases.txt", case_mem);
        if (case_word(0, COL_OMEGA0) == 0) begin
            abort_run("Case file bench/lpf_cases.txt did not load");
        end
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        // Idle after reset
        expect_quiet(20);

        for (int i = 0; i < NUM_CASES; i++) begin
            drive_case(i);
            wait_calc_done();
            check_result(i);
            expect_quiet(5);
        end

        // do_calc while busy must be dropped
        drive_case(0);
        repeat (4) @(posedge clk);
        drive_case(1);
        wait_calc_done();
        check_result(0);
        expect_quiet(200);

        // Back to back in reverse order
        for (int i = NUM_CASES - 1; i >= 0; i--) begin
            drive_case(i);
            wait_calc_done();
            check_result(i);
        end
        expect_quiet(10);

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- coef_calc/coef_regs.sv
/*
 * Working registers r0-r2 and c0-c4, DSP requests with delayed
 * product write-back, shifts and output packing
 */
module coef_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  fixp_pkg::fixp_t         tay_result,
    input  fixp_pkg::fixp_t         inv_2q,
    input  logic                    mv_r0,
    input  logic                    mv_r1,
    input  logic                    mv_r2,
    input  logic                    alpha_go,
    input  logic                    one_minus_go,
    input  logic                    shift_go,
    input  logic                    scale_go,
    input  logic                    out_go,
    input  lpf_coef_pkg::creg_idx_t scale_idx,
    output fixp_pkg::dsp_req_t      dsp_req,
    input  fixp_pkg::acc_t          p,
    output logic                    wb_busy,
    output fixp_pkg::fixp_t         alpha,
    output lpf_coef_pkg::coef_set_t coefs
);

    fixp_pkg::fixp_t         r0;
    fixp_pkg::fixp_t         r1;
    fixp_pkg::fixp_t         r2;
    fixp_pkg::fixp_t         c_reg [5];
    fixp_pkg::fixp_t         prod_q;
    logic                    om_pend;
    logic                    issue_v;
    lpf_coef_pkg::creg_idx_t issue_idx;
    logic [2:0]              tag_v;
    lpf_coef_pkg::creg_idx_t tag_idx [3];

    // --------------------
    // Request issue
    // --------------------
    always_comb begin
        dsp_req   = '0;
        issue_v   = 1'b1;
        issue_idx = 3'd1;
        if (alpha_go) begin
            dsp_req.op = fixp_pkg::DSP_MUL;
            dsp_req.a  = r1;
            dsp_req.b  = inv_2q;
        end else if (one_minus_go) begin
            dsp_req.op = fixp_pkg::DSP_SUB;
            dsp_req.a  = r2;
            dsp_req.b  = fixp_pkg::FIXP_ONE;
            dsp_req.c  = fixp_pkg::ACC_ONE;
            issue_idx  = 3'd3;
        end else if (om_pend) begin
            // Second half of the one-minus step forms 1 - alpha
            dsp_req.op = fixp_pkg::DSP_SUB;
            dsp_req.a  = c_reg[1];
            dsp_req.b  = fixp_pkg::FIXP_ONE;
            dsp_req.c  = fixp_pkg::ACC_ONE;
        end else if (scale_go) begin
            dsp_req.op = fixp_pkg::DSP_MUL;
            dsp_req.a  = c_reg[scale_idx];
            dsp_req.b  = r0;
            issue_idx  = scale_idx;
        end else begin
            issue_v = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            om_pend <= 1'b0;
            tag_v   <= '0;
        end else begin
            om_pend <= one_minus_go;
            tag_v   <= {tag_v[1:0], issue_v};
        end
    end

    assign wb_busy = (|tag_v) || om_pend;

    // --------------------
    // Registers and write-back
    // --------------------
    always_ff @(posedge clk) begin
        tag_idx[0] <= issue_idx;
        tag_idx[1] <= tag_idx[0];
        tag_idx[2] <= tag_idx[1];
        prod_q     <= p[fixp_pkg::FIXP_FRAC +: $bits(fixp_pkg::fixp_t)];
        if (mv_r0) r0 <= tay_result;
        if (mv_r1) r1 <= tay_result;
        if (mv_r2) r2 <= tay_result;
        if (shift_go) begin
            c_reg[0] <= r2 <<< 1;
            c_reg[2] <= c_reg[3] >>> 1;
            c_reg[4] <= c_reg[3] >>> 1;
        end
        if (tag_v[2]) c_reg[tag_idx[2]] <= prod_q;
    end

    assign alpha = c_reg[1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coefs <= '0;
        end else if (out_go) begin
            coefs <= '{a2: c_reg[1], a1: c_reg[0], b2: c_reg[4], b1: c_reg[3], b0: c_reg[2]};
        end else begin
            coefs <= '0;
        end
    end

endmodule

//--- coef_calc/coef_sequencer.sv
/*
 * Step program for the coefficient calculation: series calls,
 * DSP operations and register moves
 */
module coef_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     do_calc,
    input  fixp_pkg::fixp_t          omega0,
    input  fixp_pkg::fixp_t          inv_2q,
    input  fixp_pkg::fixp_t          alpha,
    output logic                     tay_start,
    output lpf_coef_pkg::taylor_fn_e tay_fn,
    output fixp_pkg::fixp_t          tay_arg,
    input  logic                     tay_done,
    output logic                     mv_r0,
    output logic                     mv_r1,
    output logic                     mv_r2,
    output logic                     alpha_go,
    output logic                     shift_go,
    output logic                     one_minus_go,
    output logic                     scale_go,
    output logic                     out_go,
    output lpf_coef_pkg::creg_idx_t  scale_idx,
    output fixp_pkg::fixp_t          inv_2q_q,
    input  logic                     wb_busy,
    output logic                     calc_done
);

    lpf_coef_pkg::seq_step_e step;
    lpf_coef_pkg::creg_idx_t scale_cnt;
    fixp_pkg::fixp_t         omega0_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step      <= lpf_coef_pkg::ST_IDLE;
            scale_cnt <= '0;
            calc_done <= 1'b0;
        end else begin
            calc_done <= (step == lpf_coef_pkg::ST_DONE);
            case (step)
                lpf_coef_pkg::ST_IDLE:
                    if (do_calc) step <= lpf_coef_pkg::ST_SIN;
                lpf_coef_pkg::ST_SIN:
                    step <= lpf_coef_pkg::ST_SIN_WAIT;
                lpf_coef_pkg::ST_SIN_WAIT:
                    if (tay_done) step <= lpf_coef_pkg::ST_COS;
                lpf_coef_pkg::ST_COS:
                    step <= lpf_coef_pkg::ST_COS_WAIT;
                lpf_coef_pkg::ST_COS_WAIT:
                    if (tay_done) step <= lpf_coef_pkg::ST_ALPHA;
                lpf_coef_pkg::ST_ALPHA:
                    step <= lpf_coef_pkg::ST_ALPHA_WAIT;
                lpf_coef_pkg::ST_ALPHA_WAIT:
                    if (!wb_busy) step <= lpf_coef_pkg::ST_INV;
                lpf_coef_pkg::ST_INV:
                    step <= lpf_coef_pkg::ST_INV_WAIT;
                lpf_coef_pkg::ST_INV_WAIT:
                    if (tay_done) step <= lpf_coef_pkg::ST_ONE_MINUS;
                lpf_coef_pkg::ST_ONE_MINUS:
                    step <= lpf_coef_pkg::ST_SHIFT;
                // Both subtractions must land before c3 is shifted
                lpf_coef_pkg::ST_SHIFT: begin
                    if (!wb_busy) begin
                        step      <= lpf_coef_pkg::ST_SCALE;
                        scale_cnt <= '0;
                    end
                end
                lpf_coef_pkg::ST_SCALE: begin
                    if (scale_cnt == lpf_coef_pkg::CREG_LAST) begin
                        step <= lpf_coef_pkg::ST_DRAIN;
                    end else begin
                        scale_cnt <= scale_cnt + 3'd1;
                    end
                end
                lpf_coef_pkg::ST_DRAIN:
                    if (!wb_busy) step <= lpf_coef_pkg::ST_DONE;
                default:
                    step <= lpf_coef_pkg::ST_IDLE;
            endcase
        end
    end

    // Inputs held for the whole calculation
    always_ff @(posedge clk) begin
        if (step == lpf_coef_pkg::ST_IDLE && do_calc) begin
            omega0_q <= omega0;
            inv_2q_q <= inv_2q;
        end
    end

    always_comb begin
        tay_fn  = lpf_coef_pkg::TAY_NONE;
        tay_arg = '0;
        case (step)
            lpf_coef_pkg::ST_SIN: begin
                tay_fn  = lpf_coef_pkg::TAY_SIN;
                tay_arg = omega0_q;
            end
            lpf_coef_pkg::ST_COS: begin
                tay_fn  = lpf_coef_pkg::TAY_COS;
                tay_arg = omega0_q;
            end
            lpf_coef_pkg::ST_INV: begin
                tay_fn  = lpf_coef_pkg::TAY_INV1PX;
                tay_arg = alpha;
            end
            default: ;
        endcase
    end

    assign tay_start    = (tay_fn != lpf_coef_pkg::TAY_NONE);
    assign mv_r1        = (step == lpf_coef_pkg::ST_SIN_WAIT) && tay_done;
    assign mv_r2        = (step == lpf_coef_pkg::ST_COS_WAIT) && tay_done;
    assign mv_r0        = (step == lpf_coef_pkg::ST_INV_WAIT) && tay_done;
    assign alpha_go     = (step == lpf_coef_pkg::ST_ALPHA);
    assign one_minus_go = (step == lpf_coef_pkg::ST_ONE_MINUS);
    assign shift_go     = (step == lpf_coef_pkg::ST_SHIFT) && !wb_busy;
    assign scale_go     = (step == lpf_coef_pkg::ST_SCALE);
    assign scale_idx    = scale_cnt;
    assign out_go       = (step == lpf_coef_pkg::ST_DONE);

endmodule

//--- common/fixp_pkg.sv
/*
 * Q2.16 sample and accumulator types, DSP slice operations,
 * DSP request format and pipeline constants
 */
package fixp_pkg;

    typedef logic signed [17:0] fixp_t;
    typedef logic signed [47:0] acc_t;

    localparam int    FIXP_FRAC   = 16;
    localparam fixp_t FIXP_ONE    = 18'sd65536;
    localparam int    DSP_LATENCY = 2;

    // 1.0 at the scale of a full product
    localparam acc_t  ACC_ONE     = acc_t'(FIXP_ONE) <<< FIXP_FRAC;

    typedef enum logic [1:0] {
        DSP_NOP = 2'd0,
        DSP_MUL = 2'd1,
        DSP_MAC = 2'd2,
        DSP_SUB = 2'd3
    } dsp_op_e;

    // All zero when the requester is idle
    typedef struct packed {
        dsp_op_e op;
        fixp_t   a;
        fixp_t   b;
        acc_t    c;
    } dsp_req_t;

endpackage

//--- common/lpf_coef_pkg.sv
/*
 * Coefficient set, series function and sequencer step encodings,
 * working register index and series constants
 */
package lpf_coef_pkg;

    typedef logic [2:0] creg_idx_t;

    localparam creg_idx_t CREG_LAST = 3'd4;

    typedef struct packed {
        fixp_pkg::fixp_t a2;
        fixp_pkg::fixp_t a1;
        fixp_pkg::fixp_t b2;
        fixp_pkg::fixp_t b1;
        fixp_pkg::fixp_t b0;
    } coef_set_t;

    typedef enum logic [1:0] {
        TAY_NONE   = 2'd0,
        TAY_SIN    = 2'd1,
        TAY_COS    = 2'd2,
        TAY_INV1PX = 2'd3
    } taylor_fn_e;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_SIN,
        ST_SIN_WAIT,
        ST_COS,
        ST_COS_WAIT,
        ST_ALPHA,
        ST_ALPHA_WAIT,
        ST_INV,
        ST_INV_WAIT,
        ST_ONE_MINUS,
        ST_SHIFT,
        ST_SCALE,
        ST_DRAIN,
        ST_DONE
    } seq_step_e;

    // Series terms in Q2.16
    localparam fixp_pkg::fixp_t TAY_SIN_K5 = 18'sd546;
    localparam fixp_pkg::fixp_t TAY_SIN_K3 = -18'sd10923;
    localparam fixp_pkg::fixp_t TAY_COS_K4 = 18'sd2731;
    localparam fixp_pkg::fixp_t TAY_COS_K2 = -18'sd32768;

endpackage

//--- design/dsp_slice.sv
/*
 * Shared two-stage multiply-add slice with two OR-merged request ports
 */
module dsp_slice (
    input  logic               clk,
    input  logic               reset,
    input  fixp_pkg::dsp_req_t req_a,
    input  fixp_pkg::dsp_req_t req_b,
    output fixp_pkg::acc_t     p
);

    fixp_pkg::dsp_req_t req_q;
    logic signed [35:0] prod;
    fixp_pkg::acc_t     prod_ext;

    // Requesters never overlap so OR acts as the mux
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_q <= '0;
        end else begin
            req_q <= fixp_pkg::dsp_req_t'(req_a | req_b);
        end
    end

    assign prod     = req_q.a * req_q.b;
    assign prod_ext = prod;

    // Stage 2
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p <= '0;
        end else begin
            case (req_q.op)
                fixp_pkg::DSP_MUL: p <= prod_ext;
                fixp_pkg::DSP_MAC: p <= req_q.c + prod_ext;
                fixp_pkg::DSP_SUB: p <= req_q.c - prod_ext;
                default:           p <= '0;
            endcase
        end
    end

endmodule

//--- design/lpf_coef_top.sv
/*
 * Biquad low-pass coefficient calculator top level
 */
module lpf_coef_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    do_calc,
    input  fixp_pkg::fixp_t         omega0,
    input  fixp_pkg::fixp_t         inv_2q,
    output lpf_coef_pkg::coef_set_t coefs,
    output logic                    calc_done
);

    logic                     tay_start;
    logic                     tay_done;
    lpf_coef_pkg::taylor_fn_e tay_fn;
    fixp_pkg::fixp_t          tay_arg;
    fixp_pkg::fixp_t          tay_result;
    logic                     mv_r0;
    logic                     mv_r1;
    logic                     mv_r2;
    logic                     alpha_go;
    logic                     shift_go;
    logic                     one_minus_go;
    logic                     scale_go;
    logic                     out_go;
    lpf_coef_pkg::creg_idx_t  scale_idx;
    fixp_pkg::fixp_t          inv_2q_q;
    fixp_pkg::fixp_t          alpha;
    logic                     wb_busy;
    fixp_pkg::dsp_req_t       regs_req;
    fixp_pkg::dsp_req_t       tay_req;
    fixp_pkg::acc_t           p;

    coef_sequencer u_coef_sequencer (
        .clk          (clk),
        .reset        (reset),
        .do_calc      (do_calc),
        .omega0       (omega0),
        .inv_2q       (inv_2q),
        .alpha        (alpha),
        .tay_start    (tay_start),
        .tay_fn       (tay_fn),
        .tay_arg      (tay_arg),
        .tay_done     (tay_done),
        .mv_r0        (mv_r0),
        .mv_r1        (mv_r1),
        .mv_r2        (mv_r2),
        .alpha_go     (alpha_go),
        .shift_go     (shift_go),
        .one_minus_go (one_minus_go),
        .scale_go     (scale_go),
        .out_go       (out_go),
        .scale_idx    (scale_idx),
        .inv_2q_q     (inv_2q_q),
        .wb_busy      (wb_busy),
        .calc_done    (calc_done)
    );

    coef_regs u_coef_regs (
        .clk          (clk),
        .reset        (reset),
        .tay_result   (tay_result),
        .inv_2q       (inv_2q_q),
        .mv_r0        (mv_r0),
        .mv_r1        (mv_r1),
        .mv_r2        (mv_r2),
        .alpha_go     (alpha_go),
        .one_minus_go (one_minus_go),
        .shift_go     (shift_go),
        .scale_go     (scale_go),
        .out_go       (out_go),
        .scale_idx    (scale_idx),
        .dsp_req      (regs_req),
        .p            (p),
        .wb_busy      (wb_busy),
        .alpha        (alpha),
        .coefs        (coefs)
    );

    taylor_unit u_taylor_unit (
        .clk     (clk),
        .reset   (reset),
        .start   (tay_start),
        .fn      (tay_fn),
        .arg     (tay_arg),
        .done    (tay_done),
        .result  (tay_result),
        .dsp_req (tay_req),
        .p       (p)
    );

    dsp_slice u_dsp_slice (
        .clk   (clk),
        .reset (reset),
        .req_a (regs_req),
        .req_b (tay_req),
        .p     (p)
    );

endmodule

//--- design/taylor_unit.sv
/*
 * Horner series evaluator for sin, cos and 1/(1+x) on the shared DSP slice
 */
module taylor_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  lpf_coef_pkg::taylor_fn_e fn,
    input  fixp_pkg::fixp_t          arg,
    output logic                     done,
    output fixp_pkg::fixp_t          result,
    output fixp_pkg::dsp_req_t       dsp_req,
    input  fixp_pkg::acc_t           p
);

    typedef enum logic [1:0] {
        T_IDLE,
        T_ISSUE,
        T_WAIT
    } tay_state_e;

    // One Horner step computes a * b + c
    typedef struct packed {
        logic            a_x;
        logic            b_x2;
        logic            to_x2;
        logic            last;
        fixp_pkg::fixp_t c;
    } tay_step_t;

    tay_state_e               state;
    lpf_coef_pkg::taylor_fn_e fn_q;
    logic [1:0]               k_q;
    logic [1:0]               wait_q;
    fixp_pkg::fixp_t          x_q;
    fixp_pkg::fixp_t          x2_q;
    fixp_pkg::fixp_t          acc_q;
    fixp_pkg::fixp_t          mac_out;
    tay_step_t                cur;

    // --------------------
    // Step tables
    // --------------------
    function automatic tay_step_t step_of(input lpf_coef_pkg::taylor_fn_e f,
                                          input logic [1:0] k);
        tay_step_t s;
        s = '0;
        case (f)
            lpf_coef_pkg::TAY_SIN: begin
                case (k)
                    2'd0:    s = '{1'b1, 1'b0, 1'b1, 1'b0, '0};
                    2'd1:    s = '{1'b0, 1'b1, 1'b0, 1'b0, lpf_coef_pkg::TAY_SIN_K3};
                    2'd2:    s = '{1'b0, 1'b1, 1'b0, 1'b0, fixp_pkg::FIXP_ONE};
                    default: s = '{1'b0, 1'b0, 1'b0, 1'b1, '0};
                endcase
            end
            lpf_coef_pkg::TAY_COS: begin
                case (k)
                    2'd0:    s = '{1'b1, 1'b0, 1'b1, 1'b0, '0};
                    2'd1:    s = '{1'b0, 1'b1, 1'b0, 1'b0, lpf_coef_pkg::TAY_COS_K2};
                    default: s = '{1'b0, 1'b1, 1'b0, 1'b1, fixp_pkg::FIXP_ONE};
                endcase
            end
            // Alternating 1, -1 terms
            lpf_coef_pkg::TAY_INV1PX: begin
                s = '{1'b0, 1'b0, 1'b0, k == 2'd3,
                      k[0] ? fixp_pkg::FIXP_ONE : -fixp_pkg::FIXP_ONE};
            end
            default: s = '0;
        endcase
        return s;
    endfunction

    assign cur     = step_of(fn_q, k_q);
    assign mac_out = p[fixp_pkg::FIXP_FRAC +: $bits(fixp_pkg::fixp_t)];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= T_IDLE;
            fn_q   <= lpf_coef_pkg::TAY_NONE;
            k_q    <= '0;
            wait_q <= '0;
            done   <= 1'b0;
            result <= '0;
        end else begin
            done   <= 1'b0;
            result <= '0;
            case (state)
                T_IDLE: begin
                    if (start) begin
                        state <= T_ISSUE;
                        fn_q  <= fn;
                        k_q   <= '0;
                    end
                end
                T_ISSUE: begin
                    state  <= T_WAIT;
                    wait_q <= 2'(fixp_pkg::DSP_LATENCY - 1);
                end
                T_WAIT: begin
                    if (wait_q != '0) begin
                        wait_q <= wait_q - 2'd1;
                    end else if (cur.last) begin
                        state  <= T_IDLE;
                        done   <= 1'b1;
                        result <= mac_out;
                    end else begin
                        state <= T_ISSUE;
                        k_q   <= k_q + 2'd1;
                    end
                end
                default: state <= T_IDLE;
            endcase
        end
    end

    // Operands and running accumulator
    always_ff @(posedge clk) begin
        if (state == T_IDLE && start) begin
            x_q <= arg;
            case (fn)
                lpf_coef_pkg::TAY_SIN: acc_q <= lpf_coef_pkg::TAY_SIN_K5;
                lpf_coef_pkg::TAY_COS: acc_q <= lpf_coef_pkg::TAY_COS_K4;
                default:               acc_q <= fixp_pkg::FIXP_ONE;
            endcase
        end else if (state == T_WAIT && wait_q == '0) begin
            if (cur.to_x2) begin
                x2_q <= mac_out;
            end else begin
                acc_q <= mac_out;
            end
        end
    end

    always_comb begin
        dsp_req = '0;
        if (state == T_ISSUE) begin
            dsp_req.op = fixp_pkg::DSP_MAC;
            dsp_req.a  = cur.a_x ? x_q : acc_q;
            dsp_req.b  = cur.b_x2 ? x2_q : x_q;
            dsp_req.c  = fixp_pkg::acc_t'(cur.c) <<< fixp_pkg::FIXP_FRAC;
        end
    end

endmodule

//--- sim.f
common/fixp_pkg.sv
common/lpf_coef_pkg.sv
design/dsp_slice.sv
design/taylor_unit.sv
coef_calc/coef_sequencer.sv
coef_calc/coef_regs.sv
design/lpf_coef_top.sv
bench/lpf_coef_tb.sv
